//--- run_sim.sh
#!/bin/sh
# Builds the vector decode stage testbench with Verilator and runs it.
# Exits 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=Vtb_vdecode_stage
LOG=sim.log

if ! verilator --binary --assert -f src.f --top-module tb_vdecode_stage \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
  echo "verilator build failed"
  exit 1
fi

# keep running past the first assertion failure so every test reports
if ! "./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with a failing status"
  exit 1
fi

cat "$LOG"

if grep -q "^No errors$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1

//--- src.f
verilog/vdec_pkg.sv
verilog/vector_ctrl_decode.sv
verilog/element_counter.sv
verilog/operand_offset_gen.sv
verilog/decode_execute_reg.sv
verilog/vdecode_stage.sv
verification/vdecode_stage_assertions.sv
verification/tb_vdecode_stage.sv

//--- verification/tb_vdecode_stage.sv
/*
  Testbench for the vector decode stage. Six directed tests with random
  vl, vstart, xs1 and mask drive the DUT on the falling edge; the bound
  checker compares every element group against its model.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_vdecode_stage;
  import vdec_pkg::*;

  localparam int VLEN       = 128;
  localparam int NUM_TESTS  = 6;
  localparam int MAX_CYCLES = NUM_TESTS * (VLEN / 2 + 20);
  localparam logic [2:0] F3_VX  = 3'b100;
  localparam logic [2:0] F3_VI  = 3'b011;
  localparam logic [2:0] F3_MVX = 3'b110;

  logic            CLK = 1'b0;
  logic            nRST;
  logic            instr_valid;
  word_t           instr;
  word_t           vl;
  word_t           vstart;
  sew_t            vsew;
  word_t           xs1;
  logic [VLEN-1:0] v0_mask;
  logic            stall;
  logic            flush;
  logic            busy;
  logic            ex_valid;
  logic            ex_last;
  op_class_t       ex_op_class;
  vreg_idx_t       ex_vd;
  vreg_idx_t       ex_vs1;
  vreg_idx_t       ex_vs2;
  offset_t         ex_vs2_offset0;
  offset_t         ex_vs2_offset1;
  offset_t         ex_woffset0;
  offset_t         ex_woffset1;
  logic [1:0]      ex_wen;
  logic [1:0]      ex_use_xs1;
  word_t           ex_imm;
  word_t           ex_vl;

  int    cycle_count = 0;
  int    tests_done = 0;
  int    tests_failed = 0;
  int    fails_before = 0;

  vdecode_stage #(.VLEN(VLEN)) u_vdecode_stage (
    .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .instr(instr), .vl(vl),
    .vstart(vstart), .vsew(vsew), .xs1(xs1), .v0_mask(v0_mask), .stall(stall),
    .flush(flush), .busy(busy), .ex_valid(ex_valid), .ex_last(ex_last),
    .ex_op_class(ex_op_class), .ex_vd(ex_vd), .ex_vs1(ex_vs1), .ex_vs2(ex_vs2),
    .ex_vs2_offset0(ex_vs2_offset0), .ex_vs2_offset1(ex_vs2_offset1),
    .ex_woffset0(ex_woffset0), .ex_woffset1(ex_woffset1), .ex_wen(ex_wen),
    .ex_use_xs1(ex_use_xs1), .ex_imm(ex_imm), .ex_vl(ex_vl)
  );

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  function automatic word_t encode_vector(logic [5:0] f6, logic vm, logic [4:0] rs2,
                                          logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd);
    return {f6, vm, rs2, rs1, f3, rd, OPC_VECTOR};
  endfunction

  // unit-stride form, mop 00 and mew 0
  function automatic word_t encode_mem(logic [6:0] opc, logic [2:0] nf, logic vm,
                                       logic [4:0] lumop, logic [2:0] width, logic [4:0] rd);
    return {nf, 1'b0, 2'b00, vm, lumop, 5'd1, width, rd, opc};
  endfunction

  task automatic send_instr(word_t ins, word_t n_vl, word_t n_vstart, sew_t sew);
    @(negedge CLK);
    instr_valid = 1'b1;
    instr       = ins;
    vl          = n_vl;
    vstart      = n_vstart;
    vsew        = sew;
    @(negedge CLK);
    instr_valid = 1'b0;
  endtask

  // busy is already high one falling edge after the strobe
  task automatic wait_idle(bit with_stall);
    while (busy) begin
      stall = with_stall ? 1'($urandom_range(1, 0)) : 1'b0;
      @(negedge CLK);
    end
    stall = 1'b0;
    repeat (2) @(negedge CLK);
  endtask

  task automatic run_instr(word_t ins, word_t n_vl, word_t n_vstart, sew_t sew, bit with_stall);
    send_instr(ins, n_vl, n_vstart, sew);
    wait_idle(with_stall);
  endtask

  task automatic finish_test(string name);
    int fails;
    fails = u_vdecode_stage.u_assertions.fail_count - fails_before;
    fails_before = u_vdecode_stage.u_assertions.fail_count;
    tests_done++;
    if (fails != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d assertion failures", tests_done, name,
             (fails == 0) ? "ok" : "FAILED", fails);
  endtask

  initial begin
    word_t vadd;
    void'($urandom(32'h8326c784));
    nRST        = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    vl          = '0;
    vstart      = '0;
    vsew        = SEW32;
    xs1         = '0;
    v0_mask     = '0;
    stall       = 1'b0;
    flush       = 1'b0;
    vadd        = encode_vector(6'b000000, 1'b1, 5'd2, 5'd1, 3'b000, 5'd3);
    #1 nRST = 1'b0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    run_instr(vadd, $urandom_range(24, 9), $urandom_range(3, 0), SEW32, 1'b0);
    finish_test("reset_and_vadd");

    // byte load under SEW32, whole-register load with nf=1, then a store
    run_instr(encode_mem(OPC_LOAD_FP, 3'd0, 1'b1, 5'd0, WIDTH8, 5'd4),
              4 * $urandom_range(8, 2), 0, SEW32, 1'b0);
    run_instr(encode_mem(OPC_LOAD_FP, 3'd1, 1'b1, LUMOP_WHOLE_REG, WIDTH8, 5'd4),
              3, 0, SEW32, 1'b0);
    run_instr(encode_mem(OPC_STORE_FP, 3'd0, 1'b1, 5'd0, WIDTH32, 5'd6),
              $urandom_range(20, 5), 0, SEW32, 1'b0);
    finish_test("load_vl_scaling");

    v0_mask = {$urandom, $urandom, $urandom, $urandom};
    run_instr(encode_vector(6'b000000, 1'b0, 5'd2, 5'd1, 3'b000, 5'd3),
              $urandom_range(31, 9), $urandom_range(3, 0), SEW32, 1'b0);
    // vstart past vl leaves one empty group
    run_instr(encode_vector(6'b000000, 1'b0, 5'd2, 5'd1, 3'b000, 5'd3), 6, 8, SEW32, 1'b0);
    finish_test("masking");

    xs1 = $urandom_range(7, 1);
    run_instr(encode_vector(F6_SLIDEDOWN, 1'b1, 5'd8, 5'd5, F3_VX, 5'd9),
              $urandom_range(20, 8), 0, SEW32, 1'b0);
    run_instr(encode_vector(F6_SLIDEUP, 1'b1, 5'd8, 5'd3, F3_VI, 5'd9),
              $urandom_range(20, 8), 0, SEW32, 1'b0);
    finish_test("slides");

    run_instr(encode_vector(F6_SLIDEUP, 1'b1, 5'd8, 5'd5, F3_MVX, 5'd9), 15, 2, SEW32, 1'b0);
    run_instr(encode_vector(F6_SLIDEDOWN, 1'b1, 5'd8, 5'd5, F3_MVX, 5'd9), 13, 0, SEW32, 1'b0);
    finish_test("slide1");

    run_instr(vadd, $urandom_range(24, 12), 0, SEW32, 1'b1);
    send_instr(vadd, 28, 0, SEW32);
    repeat (3) @(negedge CLK);
    flush = 1'b1;
    @(negedge CLK);
    flush = 1'b0;
    wait_idle(1'b0);
    // second strobe lands while the first instruction is still walking
    send_instr(vadd, 24, 0, SEW32);
    repeat (2) @(negedge CLK);
    send_instr(encode_vector(F6_SLIDEUP, 1'b1, 5'd8, 5'd3, F3_VI, 5'd9), 9, 1, SEW32);
    wait_idle(1'b0);
    finish_test("stall_flush_busy");

    $display("tests run %0d, tests failed %0d, assertion failures %0d",
             tests_done, tests_failed, u_vdecode_stage.u_assertions.fail_count);
    if (tests_failed == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/vdecode_stage_assertions.sv
/*
  Checker bound into vdecode_stage. A small model follows each accepted
  instruction through its two-lane element walk, and the assertions compare
  the execute register, busy, stall hold and flush against it.
*/
`timescale 1ns/1ps
`default_nettype none

module vdecode_stage_assertions
  import vdec_pkg::*;
#(
  parameter int VLEN = 128
) (
  input logic            CLK,
  input logic            nRST,
  input logic            instr_valid,
  input word_t           instr,
  input word_t           vl,
  input word_t           vstart,
  input sew_t            vsew,
  input word_t           xs1,
  input logic [VLEN-1:0] v0_mask,
  input logic            stall,
  input logic            flush,
  input logic            busy,
  input logic            ex_valid,
  input logic            ex_last,
  input op_class_t       ex_op_class,
  input vreg_idx_t       ex_vd,
  input vreg_idx_t       ex_vs1,
  input vreg_idx_t       ex_vs2,
  input offset_t         ex_vs2_offset0,
  input offset_t         ex_vs2_offset1,
  input offset_t         ex_woffset0,
  input offset_t         ex_woffset1,
  input logic [1:0]      ex_wen,
  input logic [1:0]      ex_use_xs1,
  input word_t           ex_imm,
  input word_t           ex_vl
);

  localparam int IW = $clog2(VLEN);
  localparam logic [2:0] F3_VX  = 3'b100;
  localparam logic [2:0] F3_VI  = 3'b011;
  localparam logic [2:0] F3_MVX = 3'b110;

  int fail_count = 0;

  // instruction in flight
  logic       m_active;
  offset_t    m_next;
  word_t      m_vl;
  word_t      m_vstart;
  logic       m_vm;
  logic       m_store;
  logic       m_up;
  logic       m_down;
  logic [2:0] m_f3;
  offset_t    m_uimm;
  logic       last_now;
  op_class_t  m_op_class;
  vreg_idx_t  m_vd;
  vreg_idx_t  m_vs1;
  vreg_idx_t  m_vs2;
  word_t      m_imm;

  // expected execute register
  logic          m_ex_valid;
  logic          m_ex_last;
  logic [1:0]    m_ex_wen;
  logic [1:0]    m_ex_use;
  offset_t [1:0] m_ex_vs2;
  offset_t [1:0] m_ex_wo;
  word_t         m_ex_vl;

  function automatic word_t calc_vl_eff(word_t ins, word_t n_vl, sew_t sew);
    int   sew_bits;
    int   eew_bits;
    logic is_mem;
    sew_bits = 8 << int'(sew);
    eew_bits = (ins[14:12] == WIDTH32) ? 32 : (ins[14:12] == WIDTH16) ? 16 : 8;
    is_mem = ((ins[6:0] == OPC_LOAD_FP) || (ins[6:0] == OPC_STORE_FP)) &&
             (ins[27:26] == 2'b00);
    if (!is_mem) return n_vl;
    if (ins[24:20] == LUMOP_WHOLE_REG) return word_t'((int'(ins[31:29]) + 1) * (VLEN / 32));
    if (eew_bits < sew_bits) return n_vl / word_t'(sew_bits / eew_bits);
    return n_vl;
  endfunction

  function automatic logic lane_in(offset_t e);
    return (word_t'(e) < m_vl) && (word_t'(e) >= m_vstart);
  endfunction

  function automatic offset_t exp_vs2(offset_t e);
    if (m_down && m_f3 == F3_VX) return e + xs1[15:0];
    if (m_down && m_f3 == F3_VI) return e + m_uimm;
    if (m_down && m_f3 == F3_MVX) return e + 16'd1;
    if (m_up && m_f3 == F3_MVX) return e - 16'd1;
    return e;
  endfunction

  function automatic offset_t exp_wo(offset_t e);
    if (m_up && m_f3 == F3_VX) return e + xs1[15:0];
    if (m_up && m_f3 == F3_VI) return e + m_uimm;
    return e;
  endfunction

  function automatic logic exp_wen(offset_t e);
    logic mask_on;
    mask_on = (word_t'(e) < word_t'(VLEN)) && v0_mask[e[IW-1:0]];
    return lane_in(e) && !m_store && (m_vm || mask_on);
  endfunction

  function automatic logic exp_use(offset_t e, logic lane0);
    return lane_in(e) &&
           ((m_up && m_f3 == F3_MVX && lane0 && word_t'(e) == m_vstart) ||
            (m_down && m_f3 == F3_MVX && word_t'(e) == m_vl - 32'd1));
  endfunction

  assign last_now = (m_vstart >= m_vl) || ((word_t'(m_next) + 32'd2) >= m_vl);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      m_active   <= 1'b0;
      m_ex_valid <= 1'b0;
      m_ex_last  <= 1'b0;
      m_ex_wen   <= 2'b00;
      m_ex_use   <= 2'b00;
    end else if (flush) begin
      m_active   <= 1'b0;
      m_ex_valid <= 1'b0;
      m_ex_last  <= 1'b0;
      m_ex_wen   <= 2'b00;
      m_ex_use   <= 2'b00;
    end else begin
      if (!stall) begin
        m_ex_valid <= m_active;
        m_ex_last  <= m_active && last_now;
        m_ex_wen   <= m_active ? {exp_wen(m_next + 16'd1), exp_wen(m_next)} : 2'b00;
        m_ex_use   <= m_active ? {exp_use(m_next + 16'd1, 1'b0), exp_use(m_next, 1'b1)} :
                                 2'b00;
        m_ex_vs2   <= {exp_vs2(m_next + 16'd1), exp_vs2(m_next)};
        m_ex_wo    <= {exp_wo(m_next + 16'd1), exp_wo(m_next)};
        m_ex_vl    <= m_vl;
        if (m_active) begin
          m_next <= m_next + 16'd2;
          if (last_now) begin
            m_active <= 1'b0;
          end
        end
      end
      // a strobe only counts while idle
      if (!m_active && instr_valid) begin
        m_active   <= 1'b1;
        m_next     <= vstart[15:0];
        m_vl       <= calc_vl_eff(instr, vl, vsew);
        m_vstart   <= vstart;
        m_vm       <= instr[25];
        m_store    <= instr[6:0] == OPC_STORE_FP;
        m_up       <= (instr[6:0] == OPC_VECTOR) && (instr[31:26] == F6_SLIDEUP);
        m_down     <= (instr[6:0] == OPC_VECTOR) && (instr[31:26] == F6_SLIDEDOWN);
        m_f3       <= instr[14:12];
        m_uimm     <= {11'd0, instr[19:15]};
        m_op_class <= (instr[6:0] == OPC_LOAD_FP)  ? OP_LOAD :
                      (instr[6:0] == OPC_STORE_FP) ? OP_STORE : OP_ARITH;
        m_vd       <= instr[11:7];
        m_vs1      <= instr[19:15];
        m_vs2      <= instr[24:20];
        m_imm      <= {{27{instr[19]}}, instr[19:15]};
      end
    end
  end

  a_reset: assert property (@(posedge CLK) !nRST |->
      !busy && !ex_valid && !ex_last && ex_wen == 2'b00 && ex_use_xs1 == 2'b00)
    else begin
      fail_count++;
      $error("** Error @%0t: outputs not cleared during reset", $time);
    end

  a_busy: assert property (@(posedge CLK) disable iff (!nRST) busy == m_active)
    else begin
      fail_count++;
      $error("** Error @%0t: busy %0b, expected %0b", $time, busy, m_active);
    end

  a_group: assert property (@(posedge CLK) disable iff (!nRST)
      ex_valid == m_ex_valid && ex_last == m_ex_last)
    else begin
      fail_count++;
      $error("** Error @%0t: valid/last %0b%0b, expected %0b%0b", $time,
             ex_valid, ex_last, m_ex_valid, m_ex_last);
    end

  a_fields: assert property (@(posedge CLK) disable iff (!nRST) ex_valid |->
      ex_op_class == m_op_class && ex_vd == m_vd && ex_vs1 == m_vs1 &&
      ex_vs2 == m_vs2 && ex_imm == m_imm)
    else begin
      fail_count++;
      $error("** Error @%0t: fields op %0d vd %0d vs1 %0d vs2 %0d imm %0h, expected %0d %0d %0d %0d %0h",
             $time, ex_op_class, ex_vd, ex_vs1, ex_vs2, ex_imm,
             m_op_class, m_vd, m_vs1, m_vs2, m_imm);
    end

  a_offsets: assert property (@(posedge CLK) disable iff (!nRST) ex_valid |->
      {ex_vs2_offset1, ex_vs2_offset0} == m_ex_vs2 && {ex_woffset1, ex_woffset0} == m_ex_wo)
    else begin
      fail_count++;
      $error("** Error @%0t: offsets vs2 %0d/%0d wr %0d/%0d, expected %0d/%0d wr %0d/%0d",
             $time, ex_vs2_offset0, ex_vs2_offset1, ex_woffset0, ex_woffset1,
             m_ex_vs2[0], m_ex_vs2[1], m_ex_wo[0], m_ex_wo[1]);
    end

  a_enables: assert property (@(posedge CLK) disable iff (!nRST)
      ex_wen == m_ex_wen && ex_use_xs1 == m_ex_use)
    else begin
      fail_count++;
      $error("** Error @%0t: wen %b use_xs1 %b, expected %b %b", $time,
             ex_wen, ex_use_xs1, m_ex_wen, m_ex_use);
    end

  a_vl: assert property (@(posedge CLK) disable iff (!nRST) ex_valid |-> ex_vl == m_ex_vl)
    else begin
      fail_count++;
      $error("** Error @%0t: ex_vl %0d, expected %0d", $time, ex_vl, m_ex_vl);
    end

  a_stall: assert property (@(posedge CLK) disable iff (!nRST) (stall && !flush) |=>
      $stable(ex_valid) && $stable(ex_last) && $stable(ex_wen) && $stable(ex_use_xs1) &&
      $stable(ex_vs2_offset0) && $stable(ex_vs2_offset1) &&
      $stable(ex_woffset0) && $stable(ex_woffset1))
    else begin
      fail_count++;
      $error("** Error @%0t: execute register changed under stall", $time);
    end

  a_flush: assert property (@(posedge CLK) disable iff (!nRST) flush |=> !ex_valid && !busy)
    else begin
      fail_count++;
      $error("** Error @%0t: flush left ex_valid or busy set", $time);
    end

endmodule

bind vdecode_stage vdecode_stage_assertions #(.VLEN(VLEN)) u_assertions (
  .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .instr(instr), .vl(vl),
  .vstart(vstart), .vsew(vsew), .xs1(xs1), .v0_mask(v0_mask), .stall(stall),
  .flush(flush), .busy(busy), .ex_valid(ex_valid), .ex_last(ex_last),
  .ex_op_class(ex_op_class), .ex_vd(ex_vd), .ex_vs1(ex_vs1), .ex_vs2(ex_vs2),
  .ex_vs2_offset0(ex_vs2_offset0), .ex_vs2_offset1(ex_vs2_offset1),
  .ex_woffset0(ex_woffset0), .ex_woffset1(ex_woffset1), .ex_wen(ex_wen),
  .ex_use_xs1(ex_use_xs1), .ex_imm(ex_imm), .ex_vl(ex_vl)
);

`default_nettype wire

//--- verilog/decode_execute_reg.sv
/*
  Pipeline register between the vector decode stage and execute.
  Loads one element group per unstalled edge; flush kills the valid group.
*/
`timescale 1ns/1ps
`default_nettype none

module decode_execute_reg
  import vdec_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       stall,
  input  logic       flush,
  input  logic       group_valid,
  input  logic       group_last,
  input  offset_t    vs2_offset0,
  input  offset_t    vs2_offset1,
  input  offset_t    woffset0,
  input  offset_t    woffset1,
  input  logic [1:0] wen,
  input  logic [1:0] use_xs1,
  input  op_class_t  op_class,
  input  vreg_idx_t  vd,
  input  vreg_idx_t  vs1,
  input  vreg_idx_t  vs2,
  input  word_t      imm,
  input  word_t      vl_eff,
  output logic       ex_valid,
  output logic       ex_last,
  output op_class_t  ex_op_class,
  output vreg_idx_t  ex_vd,
  output vreg_idx_t  ex_vs1,
  output vreg_idx_t  ex_vs2,
  output offset_t    ex_vs2_offset0,
  output offset_t    ex_vs2_offset1,
  output offset_t    ex_woffset0,
  output offset_t    ex_woffset1,
  output logic [1:0] ex_wen,
  output logic [1:0] ex_use_xs1,
  output word_t      ex_imm,
  output word_t      ex_vl
);

  // control side
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid   <= 1'b0;
      ex_last    <= 1'b0;
      ex_wen     <= '0;
      ex_use_xs1 <= '0;
    end else if (flush) begin
      ex_valid   <= 1'b0;
      ex_last    <= 1'b0;
      ex_wen     <= '0;
      ex_use_xs1 <= '0;
    end else if (!stall) begin
      ex_valid   <= group_valid;
      ex_last    <= group_valid & group_last;
      ex_wen     <= group_valid ? wen : 2'b00;
      ex_use_xs1 <= group_valid ? use_xs1 : 2'b00;
    end
  end

  // payload only matters while ex_valid is set
  always_ff @(posedge CLK) begin
    if (!stall) begin
      ex_op_class    <= op_class;
      ex_vd          <= vd;
      ex_vs1         <= vs1;
      ex_vs2         <= vs2;
      ex_vs2_offset0 <= vs2_offset0;
      ex_vs2_offset1 <= vs2_offset1;
      ex_woffset0    <= woffset0;
      ex_woffset1    <= woffset1;
      ex_imm         <= imm;
      ex_vl          <= vl_eff;
    end
  end

endmodule

`default_nettype wire

//--- verilog/element_counter.sv
/*
  Walks the element offset two lanes at a time from vstart to the effective vl.
  The first group is presented in the cycle after an instruction is accepted.
*/
`timescale 1ns/1ps
`default_nettype none

module element_counter
  import vdec_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    active,
  input  word_t   vl_eff,
  input  word_t   vstart_q,
  input  logic    stall,
  input  logic    flush,
  output offset_t base_offset,
  output logic    group_valid,
  output logic    group_last,
  output logic    done
);

  typedef enum logic {
    CNT_IDLE,
    CNT_RUN
  } cnt_state_t;

  cnt_state_t state;
  offset_t    offset_q;
  logic       empty_range;
  logic       past_end;

  // idle with a fresh instruction starts straight at vstart
  assign base_offset = (state == CNT_RUN) ? offset_q : offset_t'(vstart_q);

  assign empty_range = vstart_q >= vl_eff;
  assign past_end    = (word_t'(base_offset) + 32'd2) >= vl_eff;

  assign group_valid = active;
  assign group_last  = active & (empty_range | past_end);
  assign done        = group_last & ~stall;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= CNT_IDLE;
      offset_q <= '0;
    end else if (flush) begin
      state    <= CNT_IDLE;
    end else if (active && !stall) begin
      if (group_last) begin
        state    <= CNT_IDLE;
      end else begin
        state    <= CNT_RUN;
        offset_q <= base_offset + offset_t'(2);
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/operand_offset_gen.sv
/*
  Per-lane offset and write-enable logic for the two-lane element walk.
  Purely combinational. Slides shift the source or destination offset,
  and slide1 flags the boundary lane that takes the scalar operand.
*/
`timescale 1ns/1ps
`default_nettype none

module operand_offset_gen
  import vdec_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  offset_t         base_offset,
  input  op_class_t       op_class,
  input  vs2_src_t        vs2_src,
  input  vd_src_t         vd_src,
  input  logic            vm,
  input  word_t           uimm,
  input  word_t           xs1,
  input  word_t           vl_eff,
  input  word_t           vstart_q,
  input  logic [VLEN-1:0] v0_mask,
  output offset_t         vs2_offset0,
  output offset_t         vs2_offset1,
  output offset_t         woffset0,
  output offset_t         woffset1,
  output logic [1:0]      wen,
  output logic [1:0]      use_xs1
);

  localparam int MASK_IDX_W = $clog2(VLEN);

  offset_t elem    [2];
  offset_t vs2_off [2];
  offset_t w_off   [2];
  logic    in_range [2];
  logic    mask_bit [2];

  always_comb begin
    for (int l = 0; l < 2; l++) begin
      elem[l] = base_offset + offset_t'(l);

      case (vs2_src)
        VS2_SRC_IDX_PLUS_RS1:  vs2_off[l] = elem[l] + offset_t'(xs1);
        VS2_SRC_IDX_PLUS_UIMM: vs2_off[l] = elem[l] + offset_t'(uimm);
        VS2_SRC_IDX_PLUS_1:    vs2_off[l] = elem[l] + offset_t'(1);
        VS2_SRC_IDX_MINUS_1:   vs2_off[l] = elem[l] - offset_t'(1);
        default:               vs2_off[l] = elem[l];
      endcase

      case (vd_src)
        VD_SRC_IDX_PLUS_RS1:  w_off[l] = elem[l] + offset_t'(xs1);
        VD_SRC_IDX_PLUS_UIMM: w_off[l] = elem[l] + offset_t'(uimm);
        default:              w_off[l] = elem[l];
      endcase

      // body elements only, nothing below vstart or at and above vl
      in_range[l] = (word_t'(elem[l]) < vl_eff) && (word_t'(elem[l]) >= vstart_q);

      // mask bits past the register read as inactive
      if (word_t'(elem[l]) < word_t'(VLEN)) begin
        mask_bit[l] = v0_mask[elem[l][MASK_IDX_W-1:0]];
      end else begin
        mask_bit[l] = 1'b0;
      end

      wen[l] = in_range[l] && (op_class != OP_STORE) && (vm || mask_bit[l]);

      // slide1up fills element vstart, slide1down fills the top element
      use_xs1[l] = in_range[l] &&
                   (((vs2_src == VS2_SRC_IDX_MINUS_1) && (l == 0) &&
                     (word_t'(elem[l]) == vstart_q)) ||
                    ((vs2_src == VS2_SRC_IDX_PLUS_1) &&
                     (word_t'(elem[l]) == vl_eff - 32'd1)));
    end
  end

  assign vs2_offset0 = vs2_off[0];
  assign vs2_offset1 = vs2_off[1];
  assign woffset0    = w_off[0];
  assign woffset1    = w_off[1];

endmodule

`default_nettype wire

//--- verilog/vdec_pkg.sv
/*
  Shared widths, enums and instruction encodings for the vector decode stage.
  Every decode stage module imports this package with a wildcard import.
*/
`default_nettype none

package vdec_pkg;

  // 32-bit vector unit
  localparam int ELEN = 32;

  typedef logic [ELEN-1:0] word_t;
  // element offset, enough for VLEN up to 4096
  typedef logic [15:0]     offset_t;
  typedef logic [4:0]      vreg_idx_t;

  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } sew_t;

  // load/store width field, instr[14:12]
  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } width_t;

  typedef enum logic [1:0] {
    OP_ARITH = 2'b00,
    OP_LOAD  = 2'b01,
    OP_STORE = 2'b10
  } op_class_t;

  typedef enum logic [2:0] {
    VS2_SRC_NORMAL        = 3'd0,
    VS2_SRC_IDX_PLUS_RS1  = 3'd1,
    VS2_SRC_IDX_PLUS_UIMM = 3'd2,
    VS2_SRC_IDX_PLUS_1    = 3'd3,
    VS2_SRC_IDX_MINUS_1   = 3'd4
  } vs2_src_t;

  typedef enum logic [1:0] {
    VD_SRC_NORMAL        = 2'd0,
    VD_SRC_IDX_PLUS_RS1  = 2'd1,
    VD_SRC_IDX_PLUS_UIMM = 2'd2
  } vd_src_t;

  // major opcodes
  localparam logic [6:0] OPC_VECTOR   = 7'b1010111;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

  // funct6, shared by the slide and slide1 forms
  localparam logic [5:0] F6_SLIDEUP   = 6'b001110;
  localparam logic [5:0] F6_SLIDEDOWN = 6'b001111;

  localparam logic [4:0] LUMOP_WHOLE_REG = 5'b01000;

endpackage

`default_nettype wire

//--- verilog/vdecode_stage.sv
/*
  Top level of the vector decode stage. Accepts one instruction per strobe,
  then streams two-lane element groups into the execute register.
  VLEN is set here and passed to the decoder and the offset generator.
*/
`timescale 1ns/1ps
`default_nettype none

module vdecode_stage
  import vdec_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            instr_valid,
  input  word_t           instr,
  input  word_t           vl,
  input  word_t           vstart,
  input  sew_t            vsew,
  input  word_t           xs1,
  input  logic [VLEN-1:0] v0_mask,
  input  logic            stall,
  input  logic            flush,
  output logic            busy,
  output logic            ex_valid,
  output logic            ex_last,
  output op_class_t       ex_op_class,
  output vreg_idx_t       ex_vd,
  output vreg_idx_t       ex_vs1,
  output vreg_idx_t       ex_vs2,
  output offset_t         ex_vs2_offset0,
  output offset_t         ex_vs2_offset1,
  output offset_t         ex_woffset0,
  output offset_t         ex_woffset1,
  output logic [1:0]      ex_wen,
  output logic [1:0]      ex_use_xs1,
  output word_t           ex_imm,
  output word_t           ex_vl
);

  logic      active;
  op_class_t op_class;
  vreg_idx_t vd;
  vreg_idx_t vs1;
  vreg_idx_t vs2;
  logic      vm;
  vs2_src_t  vs2_src;
  vd_src_t   vd_src;
  word_t     imm;
  word_t     uimm;
  word_t     vl_eff;
  word_t     vstart_q;
  offset_t   base_offset;
  logic      group_valid;
  logic      group_last;
  logic      done;
  offset_t   vs2_offset0;
  offset_t   vs2_offset1;
  offset_t   woffset0;
  offset_t   woffset1;
  logic [1:0] wen;
  logic [1:0] use_xs1;

  assign busy = active;

  vector_ctrl_decode #(.VLEN(VLEN)) u_vector_ctrl_decode (
    .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .instr(instr),
    .vl(vl), .vstart(vstart), .vsew(vsew), .done(done), .flush(flush),
    .active(active), .op_class(op_class), .vd(vd), .vs1(vs1), .vs2(vs2),
    .vm(vm), .vs2_src(vs2_src), .vd_src(vd_src), .imm(imm), .uimm(uimm),
    .vl_eff(vl_eff), .vstart_q(vstart_q)
  );

  element_counter u_element_counter (
    .CLK(CLK), .nRST(nRST), .active(active), .vl_eff(vl_eff),
    .vstart_q(vstart_q), .stall(stall), .flush(flush),
    .base_offset(base_offset), .group_valid(group_valid),
    .group_last(group_last), .done(done)
  );

  operand_offset_gen #(.VLEN(VLEN)) u_operand_offset_gen (
    .base_offset(base_offset), .op_class(op_class), .vs2_src(vs2_src),
    .vd_src(vd_src), .vm(vm), .uimm(uimm), .xs1(xs1), .vl_eff(vl_eff),
    .vstart_q(vstart_q), .v0_mask(v0_mask),
    .vs2_offset0(vs2_offset0), .vs2_offset1(vs2_offset1),
    .woffset0(woffset0), .woffset1(woffset1), .wen(wen), .use_xs1(use_xs1)
  );

  decode_execute_reg u_decode_execute_reg (
    .CLK(CLK), .nRST(nRST), .stall(stall), .flush(flush),
    .group_valid(group_valid), .group_last(group_last),
    .vs2_offset0(vs2_offset0), .vs2_offset1(vs2_offset1),
    .woffset0(woffset0), .woffset1(woffset1), .wen(wen), .use_xs1(use_xs1),
    .op_class(op_class), .vd(vd), .vs1(vs1), .vs2(vs2), .imm(imm),
    .vl_eff(vl_eff),
    .ex_valid(ex_valid), .ex_last(ex_last), .ex_op_class(ex_op_class),
    .ex_vd(ex_vd), .ex_vs1(ex_vs1), .ex_vs2(ex_vs2),
    .ex_vs2_offset0(ex_vs2_offset0), .ex_vs2_offset1(ex_vs2_offset1),
    .ex_woffset0(ex_woffset0), .ex_woffset1(ex_woffset1),
    .ex_wen(ex_wen), .ex_use_xs1(ex_use_xs1), .ex_imm(ex_imm), .ex_vl(ex_vl)
  );

endmodule

`default_nettype wire

//--- verilog/vector_ctrl_decode.sv
/*
  Captures an accepted vector instruction with its CSR values and decodes it.
  Holds active from acceptance until the element walk reports done or a flush.
  Produces the operand offset sources and the effective element count.
*/
`timescale 1ns/1ps
`default_nettype none

module vector_ctrl_decode
  import vdec_pkg::*;
#(
  parameter int VLEN = 128
) (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      instr_valid,
  input  word_t     instr,
  input  word_t     vl,
  input  word_t     vstart,
  input  sew_t      vsew,
  input  logic      done,
  input  logic      flush,
  output logic      active,
  output op_class_t op_class,
  output vreg_idx_t vd,
  output vreg_idx_t vs1,
  output vreg_idx_t vs2,
  output logic      vm,
  output vs2_src_t  vs2_src,
  output vd_src_t   vd_src,
  output word_t     imm,
  output word_t     uimm,
  output word_t     vl_eff,
  output word_t     vstart_q
);

  // funct3 operand categories used by the slides
  localparam logic [2:0] F3_OPIVX = 3'b100;
  localparam logic [2:0] F3_OPIVI = 3'b011;
  localparam logic [2:0] F3_OPMVX = 3'b110;
  localparam int ELEMS_PER_REG = VLEN / ELEN;

  word_t  instr_q;
  word_t  vl_q;
  sew_t   sew_q;
  logic   accept;
  logic   unit_stride;
  logic   whole_reg;
  width_t eew;
  logic [1:0] eew_shift;
  logic [2:0] nf;
  logic [4:0] imm5;

  // strobes arriving while busy are dropped
  assign accept = instr_valid & ~active;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      active <= 1'b0;
    end else if (flush) begin
      active <= 1'b0;
    end else if (accept) begin
      active <= 1'b1;
    end else if (done) begin
      active <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      instr_q  <= instr;
      vl_q     <= vl;
      vstart_q <= vstart;
      sew_q    <= vsew;
    end
  end

  assign vd   = instr_q[11:7];
  assign vs1  = instr_q[19:15];
  assign vs2  = instr_q[24:20];
  assign vm   = instr_q[25];
  assign nf   = instr_q[31:29];
  assign imm5 = instr_q[19:15];
  assign eew  = width_t'(instr_q[14:12]);
  assign imm  = {{27{imm5[4]}}, imm5};
  assign uimm = {27'd0, imm5};

  assign op_class = (instr_q[6:0] == OPC_LOAD_FP)  ? OP_LOAD :
                    (instr_q[6:0] == OPC_STORE_FP) ? OP_STORE : OP_ARITH;

  // slide forms pick which side of the move carries the offset
  always_comb begin
    vs2_src = VS2_SRC_NORMAL;
    vd_src  = VD_SRC_NORMAL;
    if (instr_q[6:0] == OPC_VECTOR) begin
      if (instr_q[31:26] == F6_SLIDEUP) begin
        case (instr_q[14:12])
          F3_OPIVX: vd_src  = VD_SRC_IDX_PLUS_RS1;
          F3_OPIVI: vd_src  = VD_SRC_IDX_PLUS_UIMM;
          F3_OPMVX: vs2_src = VS2_SRC_IDX_MINUS_1;
          default:  vs2_src = VS2_SRC_NORMAL;
        endcase
      end else if (instr_q[31:26] == F6_SLIDEDOWN) begin
        case (instr_q[14:12])
          F3_OPIVX: vs2_src = VS2_SRC_IDX_PLUS_RS1;
          F3_OPIVI: vs2_src = VS2_SRC_IDX_PLUS_UIMM;
          F3_OPMVX: vs2_src = VS2_SRC_IDX_PLUS_1;
          default:  vs2_src = VS2_SRC_NORMAL;
        endcase
      end
    end
  end

  // mop 00 is unit stride for both loads and stores
  assign unit_stride = (op_class != OP_ARITH) && (instr_q[27:26] == 2'b00);
  assign whole_reg   = unit_stride && (instr_q[24:20] == LUMOP_WHOLE_REG);

  // narrower EEW packs more elements per vl
  always_comb begin
    eew_shift = 2'd0;
    case (sew_q)
      SEW32: begin
        if (eew == WIDTH8) begin
          eew_shift = 2'd2;
        end else if (eew == WIDTH16) begin
          eew_shift = 2'd1;
        end
      end
      SEW16: begin
        if (eew == WIDTH8) begin
          eew_shift = 2'd1;
        end
      end
      default: eew_shift = 2'd0;
    endcase
  end

  assign vl_eff = whole_reg   ? (word_t'(nf) + 32'd1) * word_t'(ELEMS_PER_REG) :
                  unit_stride ? vl_q >> eew_shift : vl_q;

endmodule

`default_nettype wire
